/* mac_subset.f */
logic/mac_pkg.sv
logic/tx_frame_reader.sv
logic/precog_scheduler.sv
logic/strobe_shaper.sv
logic/mac_subset.sv
verif/mac_subset_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the mac_subset testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f mac_subset.f \
	--top-module mac_subset_tb \
	--Mdir obj_dir \
	-o mac_subset_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit $status
fi

./obj_dir/mac_subset_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

/* verif/mac_subset_tb.sv */
`timescale 1ns/100ps

module mac_subset_tb
	import mac_pkg::*;
;

	localparam int N_FRAMES = 20;
	localparam int WD_NS = N_FRAMES * (60 + 2 * IFG + LATENCY + 40) * 4 * 100;

	logic tx_clk, arst_n, ce, scanner_busy, tx_mac_start, tx_mac_done;
	logic strobe_s, strobe_l;
	logic [7:0] mac_data;
	logic [MAC_AW-1:0] host_raddr, buf_start_addr;
	buf_word_u host_rdata;
	buf_word_u ram [0:(1<<MAC_AW)-1];

	logic [31:0] lfsr;
	int burst_left, sent_cnt, thresh;
	logic [PAW-1:0] cur_len;
	logic [7:0] exp_q[$];

	// reference model state as seen between edges
	logic m_meta, m_sync, m_cts, exp_s, exp_l;
	logic [PAW-1:0] m_quiet;
	logic [STRETCH-1:0] cts_hist, s_hist;
	logic run_prev, ce_prev, busy_prev, req_prev, cond_prev, s_prev, done_prev;

	mac_subset UUT (
		.tx_clk(tx_clk), .arst_n(arst_n), .ce(ce),
		.host_raddr(host_raddr), .host_rdata(host_rdata),
		.buf_start_addr(buf_start_addr),
		.tx_mac_start(tx_mac_start), .tx_mac_done(tx_mac_done),
		.scanner_busy(scanner_busy),
		.strobe_s(strobe_s), .strobe_l(strobe_l), .mac_data(mac_data)
	);

	always #50 tx_clk = ~tx_clk;

	// host ram with a registered read port
	always @(posedge tx_clk) begin
		host_rdata <= ram[host_raddr];
	end

	// galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
		return v;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH mac_data got 0x%0h expected 0x%0h", got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_len(input string name, input logic [PAW-1:0] got,
			input logic [PAW-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// ce is high about 3/4 of the time
	// scanner alternates quiet gaps and busy bursts
	always @(posedge tx_clk) begin
		#10;
		ce = (rand_bits(2) != 32'd0);
		if (burst_left == 0) begin
			scanner_busy = ~scanner_busy;
			if (scanner_busy) burst_left = 1 + int'(rand_bits(4));
			else burst_left = 160 + int'(rand_bits(9));
		end else begin
			burst_left--;
		end
	end

	// model steps on the edge that just passed and then compares
	always @(negedge tx_clk) begin
		if (!arst_n || !run_prev) begin
			m_meta = 1'b0;
			m_sync = 1'b0;
			m_quiet = '0;
			m_cts = 1'b0;
			cts_hist = '0;
			s_hist = '0;
		end else begin
			if (ce_prev) begin
				if (m_sync) m_quiet = '0;
				else if (m_quiet != '1) m_quiet = m_quiet + PAW'(1);
				cts_hist = {cts_hist[STRETCH-2:0], m_cts};
				s_hist = {s_hist[STRETCH-2:0], s_prev};
				if (!req_prev) m_cts = 1'b0;
				else if (cond_prev) m_cts = 1'b1;
			end
			// synchronizer ignores ce
			m_sync = m_meta;
			m_meta = busy_prev;
		end
		run_prev = arst_n;
		// request timing follows the reader's header fetch
		exp_s = cts_hist[STRETCH-1] & UUT.req;
		exp_l = m_cts | (|s_hist);
		if (arst_n) begin
			if (strobe_s && !strobe_l) abort_run("strobe_s is high while strobe_l is low");
			check_bit("strobe_s", strobe_s, exp_s);
			check_bit("strobe_l", strobe_l, exp_l);
			if (strobe_s) begin
				if (exp_q.size() == 0) abort_run("payload strobe with no byte left to send");
				check_byte(mac_data, exp_q[0]);
				// byte is only consumed on an enabled edge
				if (ce) begin
					void'(exp_q.pop_front());
					sent_cnt++;
				end
			end
			if (tx_mac_done && !done_prev) check_len("byte_count", PAW'(sent_cnt), cur_len);
		end
		thresh = int'(cur_len) + 2 * IFG;
		if (thresh > LATENCY) thresh = LATENCY;
		cond_prev = UUT.req && (int'(m_quiet) >= thresh);
		ce_prev = ce;
		busy_prev = scanner_busy;
		req_prev = UUT.req;
		s_prev = exp_s;
		done_prev = tx_mac_done;
	end

	// write the header and payload words and queue the expected bytes low byte first
	task automatic load_frame(input logic [MAC_AW-1:0] addr, input logic [PAW-1:0] len);
		buf_word_u w;
		logic [MAC_AW-1:0] wa;
		int nwords;
		nwords = (int'(len) + 1) / 2;
		w.hdr.rsvd = 5'(rand_bits(5));
		w.hdr.len = len;
		ram[addr] = w;
		for (int i = 0; i < nwords; i++) begin
			wa = addr + MAC_AW'(i + 1);
			w.data.lo = 8'(rand_bits(8));
			w.data.hi = 8'(rand_bits(8));
			ram[wa] = w;
			exp_q.push_back(w.data.lo);
			if (2 * i + 1 < int'(len)) exp_q.push_back(w.data.hi);
		end
	endtask

	task automatic run_frame();
		logic [MAC_AW-1:0] addr;
		int hold;
		@(negedge tx_clk);
		addr = MAC_AW'(rand_bits(MAC_AW));
		cur_len = PAW'(rand_bits(6) % 61);
		sent_cnt = 0;
		load_frame(addr, cur_len);
		@(posedge tx_clk);
		#10;
		buf_start_addr = addr;
		tx_mac_start = 1'b1;
		while (!tx_mac_done) @(negedge tx_clk);
		// done must hold as long as start does
		hold = 1 + int'(rand_bits(3));
		repeat (hold) begin
			@(negedge tx_clk);
			check_bit("tx_mac_done", tx_mac_done, 1'b1);
		end
		@(posedge tx_clk);
		#10;
		tx_mac_start = 1'b0;
		while (tx_mac_done) @(negedge tx_clk);
	endtask

	initial begin
		#(WD_NS);
		abort_run("timeout, the frames did not finish within the watchdog limit");
	end

	initial begin
		tx_clk = 1'b0;
		arst_n = 1'b0;
		ce = 1'b0;
		scanner_busy = 1'b0;
		tx_mac_start = 1'b0;
		buf_start_addr = '0;
		host_rdata <= '0;
		burst_left = 0;
		sent_cnt = 0;
		cur_len = '0;
		run_prev = 1'b0;
		lfsr = 32'h5490;
		for (int i = 0; i < (1 << MAC_AW); i++) ram[i] = 16'hfc00 ^ 16'(i);
		repeat (2) @(posedge tx_clk);
		#10;
		arst_n = 1'b1;
		// all quiet after reset before any start
		repeat (3) begin
			@(negedge tx_clk);
			check_bit("strobe_s", strobe_s, 1'b0);
			check_bit("strobe_l", strobe_l, 1'b0);
			check_bit("tx_mac_done", tx_mac_done, 1'b0);
		end
		for (int f = 0; f < N_FRAMES; f++) run_frame();
		@(negedge tx_clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* logic/mac_subset.sv */
`timescale 1ns/100ps

module mac_subset
	import mac_pkg::*;
(
	input logic tx_clk,
	input logic arst_n,
	input logic ce,
	// external dual port ram, read side
	output logic [MAC_AW-1:0] host_raddr,
	input buf_word_u host_rdata,
	// frame location, held while start is high
	input logic [MAC_AW-1:0] buf_start_addr,
	// four phase start and done
	input logic tx_mac_start,
	output logic tx_mac_done,
	// from the input scanner, not on tx_clk
	input logic scanner_busy,
	// toward preamble and CRC insertion
	output logic strobe_s,
	output logic strobe_l,
	output logic [7:0] mac_data
);

	logic req;
	logic [PAW-1:0] len_req;
	logic clear_to_send;
	logic mac_strobe;

	tx_frame_reader u_reader (
		.tx_clk(tx_clk),
		.arst_n(arst_n),
		.ce(ce),
		.host_rdata(host_rdata),
		.buf_start_addr(buf_start_addr),
		.tx_mac_start(tx_mac_start),
		.mac_strobe(mac_strobe),
		.host_raddr(host_raddr),
		.tx_mac_done(tx_mac_done),
		.req(req),
		.len_req(len_req),
		.mac_data(mac_data)
	);

	precog_scheduler u_sched (
		.tx_clk(tx_clk),
		.arst_n(arst_n),
		.ce(ce),
		.scanner_busy(scanner_busy),
		.req(req),
		.len_req(len_req),
		.clear_to_send(clear_to_send)
	);

	strobe_shaper u_shaper (
		.tx_clk(tx_clk),
		.arst_n(arst_n),
		.ce(ce),
		.clear_to_send(clear_to_send),
		.req(req),
		.strobe_s(mac_strobe),
		.strobe_l(strobe_l)
	);

	// payload strobe also paces the reader
	assign strobe_s = mac_strobe;

endmodule

/* logic/strobe_shaper.sv */
`timescale 1ns/100ps

module strobe_shaper
	import mac_pkg::*;
(
	input logic tx_clk,
	input logic arst_n,
	input logic ce,
	input logic clear_to_send,
	input logic req,
	output logic strobe_s,
	output logic strobe_l
);

	// grant history, the far end opens the payload window
	logic [STRETCH-1:0] cts_sr;
	// payload history, keeps strobe_l up for the CRC slots
	logic [STRETCH-1:0] s_sr;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			cts_sr <= '0;
			s_sr <= '0;
		end else if (ce) begin
			cts_sr <= {cts_sr[STRETCH-2:0], clear_to_send};
			s_sr <= {s_sr[STRETCH-2:0], strobe_s};
		end
	end

	// payload starts STRETCH slots after the grant, ends with req
	assign strobe_s = cts_sr[STRETCH-1] & req;

	// lead slots come from the grant itself
	// any payload in the last STRETCH slots keeps the trailer going
	assign strobe_l = clear_to_send | (|s_sr);

	// grant must still be up under every payload byte
	a_s_in_l: assert property (@(posedge tx_clk) disable iff (!arst_n)
		strobe_s |-> strobe_l);

endmodule

/* logic/precog_scheduler.sv */
`timescale 1ns/100ps

module precog_scheduler
	import mac_pkg::*;
(
	input logic tx_clk,
	input logic arst_n,
	input logic ce,
	input logic scanner_busy,
	input logic req,
	input logic [PAW-1:0] len_req,
	output logic clear_to_send
);

	logic busy_meta;
	logic busy_sync;
	// cycles since the scanner last reported busy
	logic [PAW-1:0] quiet_cnt;
	// one extra bit so the padding cannot wrap
	logic [PAW:0] width;
	logic [PAW:0] thresh;
	logic quiet_ok;

	// scanner runs on its own clock
	// two flops clocked on every tx_clk whether or not ce is high
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_meta <= 1'b0;
			busy_sync <= 1'b0;
		end else begin
			busy_meta <= scanner_busy;
			busy_sync <= busy_meta;
		end
	end

	// quiet counter restarts on any busy and sticks at all ones
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			quiet_cnt <= '0;
		end else if (ce) begin
			if (busy_sync) begin
				quiet_cnt <= '0;
			end else if (~&quiet_cnt) begin
				quiet_cnt <= quiet_cnt + PAW'(1);
			end
		end
	end

	// frame plus gap on both sides
	assign width = {1'b0, len_req} + (PAW+1)'(2 * IFG);

	// long frames only wait for LATENCY
	assign thresh = (width < (PAW+1)'(LATENCY)) ? width : (PAW+1)'(LATENCY);

	assign quiet_ok = ({1'b0, quiet_cnt} >= thresh);

	// grant is sticky and ignores busy once given
	// drops on the first ce edge that sees req low
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			clear_to_send <= 1'b0;
		end else if (ce) begin
			if (!req) begin
				clear_to_send <= 1'b0;
			end else if (quiet_ok) begin
				clear_to_send <= 1'b1;
			end
		end
	end

	// a grant lands while its request is still up
	a_cts_needs_req: assert property (@(posedge tx_clk) disable iff (!arst_n)
		$rose(clear_to_send) |-> req);

endmodule

/* logic/tx_frame_reader.sv */
`timescale 1ns/100ps

module tx_frame_reader
	import mac_pkg::*;
(
	input logic tx_clk,
	input logic arst_n,
	input logic ce,
	input buf_word_u host_rdata,
	input logic [MAC_AW-1:0] buf_start_addr,
	input logic tx_mac_start,
	input logic mac_strobe,
	output logic [MAC_AW-1:0] host_raddr,
	output logic tx_mac_done,
	output logic req,
	output logic [PAW-1:0] len_req,
	output logic [7:0] mac_data
);

	logic [1:0] state;
	logic start_r;
	logic start_d;
	logic start_rise;
	// read data not yet valid for the current address
	logic rd_wait;
	// header already taken, fetch is now after the first data word
	logic hdr_ok;
	// 0 while the first byte of cur_word is on mac_data
	logic second;
	logic [PAW-1:0] bytes_left;
	buf_word_u cur_word;
	logic hdr_take;
	logic prime_take;
	logic byte_take;
	logic last_take;
	logic refill;

	// start sampled once, edge found against the previous sample
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			start_r <= 1'b0;
			start_d <= 1'b0;
		end else if (ce) begin
			start_r <= tx_mac_start;
			start_d <= start_r;
		end
	end

	assign start_rise = start_r & ~start_d;

	// ram read is one tx_clk, address stays put while ce is low
	// so two ce edges after an address change the word is there
	assign hdr_take = (state == ST_FETCH) && !rd_wait && !hdr_ok;
	assign prime_take = (state == ST_FETCH) && !rd_wait && hdr_ok;
	assign byte_take = (state == ST_SEND) && mac_strobe;
	assign last_take = byte_take && (bytes_left == PAW'(1));
	// second byte gone, swap in the word the ram already holds
	assign refill = byte_take && second && !last_take;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			rd_wait <= 1'b0;
			hdr_ok <= 1'b0;
			second <= 1'b0;
			req <= 1'b0;
			len_req <= '0;
			bytes_left <= '0;
		end else if (ce) begin
			case (state)
				ST_IDLE: begin
					if (start_rise) begin
						state <= ST_FETCH;
						rd_wait <= 1'b1;
						hdr_ok <= 1'b0;
					end
				end
				ST_FETCH: begin
					if (rd_wait) begin
						rd_wait <= 1'b0;
					end else if (!hdr_ok) begin
						len_req <= host_rdata.hdr.len;
						bytes_left <= host_rdata.hdr.len;
						// empty frame goes straight to done, no req
						if (host_rdata.hdr.len == '0) begin
							state <= ST_DONE;
						end else begin
							hdr_ok <= 1'b1;
							rd_wait <= 1'b1;
						end
					end else begin
						// first data word in hand, ask to send
						req <= 1'b1;
						second <= 1'b0;
						state <= ST_SEND;
					end
				end
				ST_SEND: begin
					if (byte_take) begin
						bytes_left <= bytes_left - PAW'(1);
						second <= ~second;
						if (last_take) begin
							req <= 1'b0;
							state <= ST_DONE;
						end
					end
				end
				default: begin
					// hold done until host lets go of start
					if (!start_r) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// address and word buffer
	always_ff @(posedge tx_clk) begin
		if (ce) begin
			if ((state == ST_IDLE) && start_rise) begin
				host_raddr <= buf_start_addr;
			end else if (hdr_take || prime_take || refill) begin
				host_raddr <= host_raddr + MAC_AW'(1);
			end
			if (prime_take || refill) begin
				cur_word <= host_rdata;
			end
		end
	end

	assign tx_mac_done = (state == ST_DONE);

	// byte order flips which half goes out first
	assign mac_data = (second ^ (BIG_ENDIAN != 0)) ? cur_word.data.hi : cur_word.data.lo;

	// done is only raised after req has dropped
	a_done_req_excl: assert property (@(posedge tx_clk) disable iff (!arst_n)
		!(tx_mac_done && req));

	// scheduler and shaper see one length per request
	a_len_stable: assert property (@(posedge tx_clk) disable iff (!arst_n)
		req && $past(req) |-> len_req == $past(len_req));

endmodule

/* logic/mac_pkg.sv */
package mac_pkg;

	// host ram word address width, one word is 16 bits
	localparam int MAC_AW = 10;

	// width of the length field and of the packet width math
	localparam int PAW = 11;

	// lead and trailer slots on strobe_l, preamble before and CRC after
	// must be at least 2
	localparam int STRETCH = 4;

	// padding per side added to the frame length before asking the scanner
	localparam int IFG = 24;

	// upper bound on the quiet window we ever wait for
	localparam int LATENCY = 256;

	// byte order inside a data word, 0 sends the low byte first
	localparam int BIG_ENDIAN = 0;

	// reader FSM encodings
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_FETCH = 2'd1;
	localparam logic [1:0] ST_SEND = 2'd2;
	localparam logic [1:0] ST_DONE = 2'd3;

	// one host buffer word
	// first word of a frame is read as hdr, the rest as data
	typedef union packed {
		struct packed {
			logic [4:0] rsvd;
			logic [PAW-1:0] len;
		} hdr;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} data;
	} buf_word_u;

endpackage
